// ==== hw/rv_isa_pkg.sv ====
package rv_isa_pkg;

    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_OP_IMM = 7'b0010011,
        OP_AUIPC  = 7'b0010111,
        OP_STORE  = 7'b0100011,
        OP_OP     = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        BEQ  = 3'd0,
        BNE  = 3'd1,
        BLT  = 3'd4,
        BGE  = 3'd5,
        BLTU = 3'd6,
        BGEU = 3'd7
    } branch_f3_e;

    typedef enum logic [2:0] {
        F3_ADD  = 3'd0, // ADD or SUB
        F3_SLL  = 3'd1,
        F3_SLT  = 3'd2,
        F3_SLTU = 3'd3,
        F3_XOR  = 3'd4,
        F3_SR   = 3'd5, // SRL or SRA
        F3_OR   = 3'd6,
        F3_AND  = 3'd7
    } alu_f3_e;

    // bit 2 marks the unsigned loads
    typedef enum logic [2:0] {
        MEM_B  = 3'd0,
        MEM_H  = 3'd1,
        MEM_W  = 3'd2,
        MEM_BU = 3'd4,
        MEM_HU = 3'd5
    } mem_f3_e;

    typedef enum logic [6:0] {
        F7_BASE = 7'h00,
        F7_ALT  = 7'h20
    } funct7_e;

endpackage

// ==== hw/rv_core_pkg.sv ====
package rv_core_pkg;

    localparam int XLEN = 32;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_B // lui
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_NONE,
        WB_ALU,
        WB_PC4,
        WB_MEM
    } wb_src_e;

endpackage

// ==== hw/rv_alu.sv ====
module rv_alu (
    input  rv_core_pkg::alu_op_e op,
    input  logic [rv_core_pkg::XLEN-1:0] a,
    input  logic [rv_core_pkg::XLEN-1:0] b,
    output logic [rv_core_pkg::XLEN-1:0] result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            rv_core_pkg::ALU_ADD:    result = a + b;
            rv_core_pkg::ALU_SUB:    result = a - b;
            rv_core_pkg::ALU_SLT:    result = {31'd0, $signed(a) < $signed(b)};
            rv_core_pkg::ALU_SLTU:   result = {31'd0, a < b};
            rv_core_pkg::ALU_AND:    result = a & b;
            rv_core_pkg::ALU_OR:     result = a | b;
            rv_core_pkg::ALU_XOR:    result = a ^ b;
            rv_core_pkg::ALU_SLL:    result = a << shamt;
            rv_core_pkg::ALU_SRL:    result = a >> shamt;
            rv_core_pkg::ALU_SRA:    result = $signed(a) >>> shamt;
            rv_core_pkg::ALU_PASS_B: result = b;
            default:                 result = a + b;
        endcase
    end

endmodule

// ==== hw/rv_decoder.sv ====
module rv_decoder (
    input  logic [31:0] instruction,
    output rv_isa_pkg::opcode_e opcode,
    output logic [4:0] rd,
    output logic [4:0] rs1,
    output logic [4:0] rs2,
    output logic [2:0] funct3,
    output logic [31:0] immediate,
    output rv_core_pkg::alu_op_e alu_op,
    output logic alu_use_immediate,
    output logic alu_use_pc,
    output logic is_branch,
    output logic is_jal,
    output logic is_jalr,
    output logic is_load,
    output logic is_store,
    output rv_core_pkg::wb_src_e wb_src
);

    logic [31:0] i_imm, s_imm, b_imm, u_imm, j_imm;
    logic alt;

    function automatic rv_core_pkg::alu_op_e alu_select(input logic [2:0] f3, input logic sub_ok,
                                                        input logic alt_form);
        rv_core_pkg::alu_op_e op;
        case (rv_isa_pkg::alu_f3_e'(f3))
            rv_isa_pkg::F3_ADD:  op = (alt_form && sub_ok) ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
            rv_isa_pkg::F3_SLL:  op = rv_core_pkg::ALU_SLL;
            rv_isa_pkg::F3_SLT:  op = rv_core_pkg::ALU_SLT;
            rv_isa_pkg::F3_SLTU: op = rv_core_pkg::ALU_SLTU;
            rv_isa_pkg::F3_XOR:  op = rv_core_pkg::ALU_XOR;
            rv_isa_pkg::F3_SR:   op = alt_form ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
            rv_isa_pkg::F3_OR:   op = rv_core_pkg::ALU_OR;
            default:             op = rv_core_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode = rv_isa_pkg::opcode_e'(instruction[6:0]);
    assign rd     = instruction[11:7];
    assign funct3 = instruction[14:12];
    assign rs1    = instruction[19:15];
    assign rs2    = instruction[24:20];
    assign alt    = rv_isa_pkg::funct7_e'(instruction[31:25]) == rv_isa_pkg::F7_ALT;

    assign i_imm = {{20{instruction[31]}}, instruction[31:20]};
    assign s_imm = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign b_imm = {{20{instruction[31]}}, instruction[7], instruction[30:25],
                    instruction[11:8], 1'b0};
    assign u_imm = {instruction[31:12], 12'h000};
    assign j_imm = {{12{instruction[31]}}, instruction[19:12], instruction[20],
                    instruction[30:21], 1'b0};

    always_comb begin
        immediate         = i_imm;
        alu_op            = rv_core_pkg::ALU_ADD;
        alu_use_immediate = 1'b1;
        alu_use_pc        = 1'b0;
        is_branch         = 1'b0;
        is_jal            = 1'b0;
        is_jalr           = 1'b0;
        is_load           = 1'b0;
        is_store          = 1'b0;
        wb_src            = rv_core_pkg::WB_NONE; // unknown opcodes fall through here
        case (opcode)
            rv_isa_pkg::OP_OP: begin
                alu_op            = alu_select(funct3, 1'b1, alt);
                alu_use_immediate = 1'b0;
                wb_src            = rv_core_pkg::WB_ALU;
            end
            rv_isa_pkg::OP_OP_IMM: begin
                alu_op = alu_select(funct3, 1'b0, alt); // no SUBI
                wb_src = rv_core_pkg::WB_ALU;
            end
            rv_isa_pkg::OP_LUI: begin
                immediate = u_imm;
                alu_op    = rv_core_pkg::ALU_PASS_B;
                wb_src    = rv_core_pkg::WB_ALU;
            end
            rv_isa_pkg::OP_AUIPC: begin
                immediate  = u_imm;
                alu_use_pc = 1'b1;
                wb_src     = rv_core_pkg::WB_ALU;
            end
            rv_isa_pkg::OP_LOAD: begin
                is_load = 1'b1;
                wb_src  = rv_core_pkg::WB_MEM;
            end
            rv_isa_pkg::OP_STORE: begin
                immediate = s_imm;
                is_store  = 1'b1;
            end
            rv_isa_pkg::OP_BRANCH: begin
                immediate = b_imm;
                is_branch = 1'b1;
            end
            rv_isa_pkg::OP_JAL: begin
                immediate = j_imm;
                is_jal    = 1'b1;
                wb_src    = rv_core_pkg::WB_PC4;
            end
            rv_isa_pkg::OP_JALR: begin
                is_jalr = 1'b1; // target from rs1 + imm in the ALU
                wb_src  = rv_core_pkg::WB_PC4;
            end
            default: ;
        endcase
    end

endmodule

// ==== hw/rv_core.sv ====
module rv_core (
    input  logic clock,
    input  logic reset,
    output logic [31:0] program_address,
    input  logic [31:0] instruction,
    output logic [31:0] data_address,
    output logic [2:0] data_func3,
    output logic data_write,
    output logic [31:0] data_write_data,
    input  logic [31:0] data_read_data
);

    logic [rv_core_pkg::XLEN-1:0] pc, next_pc, pc_plus4;
    logic [rv_core_pkg::XLEN-1:0] regs [32];
    logic post_reset;   // one cycle while the first word is fetched
    logic load_pending; // bubble cycle of a load

    logic [4:0] rd, rs1, rs2;
    logic [2:0] funct3;
    logic [31:0] immediate;
    rv_core_pkg::alu_op_e alu_op;
    rv_core_pkg::wb_src_e wb_src;
    logic alu_use_immediate, alu_use_pc;
    logic is_branch, is_jal, is_jalr, is_load, is_store;

    logic [rv_core_pkg::XLEN-1:0] rs1_value, rs2_value, alu_a, alu_b, alu_result, wb_data;
    logic branch_taken, wb_enable;

    rv_decoder rv_decoder_i (
        .instruction       (instruction),
        .opcode            (),
        .rd                (rd),
        .rs1               (rs1),
        .rs2               (rs2),
        .funct3            (funct3),
        .immediate         (immediate),
        .alu_op            (alu_op),
        .alu_use_immediate (alu_use_immediate),
        .alu_use_pc        (alu_use_pc),
        .is_branch         (is_branch),
        .is_jal            (is_jal),
        .is_jalr           (is_jalr),
        .is_load           (is_load),
        .is_store          (is_store),
        .wb_src            (wb_src)
    );

    assign rs1_value = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_value = (rs2 == 5'd0) ? '0 : regs[rs2];
    assign alu_a     = alu_use_pc ? pc : rs1_value;
    assign alu_b     = alu_use_immediate ? immediate : rs2_value;
    assign pc_plus4  = pc + 32'd4;

    rv_alu rv_alu_i (
        .op     (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result)
    );

    always_comb begin
        case (rv_isa_pkg::branch_f3_e'(funct3))
            rv_isa_pkg::BEQ:  branch_taken = rs1_value == rs2_value;
            rv_isa_pkg::BNE:  branch_taken = rs1_value != rs2_value;
            rv_isa_pkg::BLT:  branch_taken = $signed(rs1_value) < $signed(rs2_value);
            rv_isa_pkg::BGE:  branch_taken = $signed(rs1_value) >= $signed(rs2_value);
            rv_isa_pkg::BLTU: branch_taken = rs1_value < rs2_value;
            rv_isa_pkg::BGEU: branch_taken = rs1_value >= rs2_value;
            default:          branch_taken = 1'b0;
        endcase
    end

    always_comb begin
        if (post_reset) begin
            next_pc = '0;
        end else if (load_pending) begin
            next_pc = pc_plus4;
        end else if (is_load && rd != 5'd0) begin
            next_pc = pc; // hold for the bubble
        end else if (is_jal || (is_branch && branch_taken)) begin
            next_pc = pc + immediate;
        end else if (is_jalr) begin
            next_pc = {alu_result[31:1], 1'b0};
        end else begin
            next_pc = pc_plus4;
        end
    end

    assign program_address = next_pc;

    assign data_address    = alu_result; // rs1 + imm
    assign data_func3      = funct3;
    assign data_write      = is_store && !post_reset;
    assign data_write_data = rs2_value;

    always_comb begin
        case (wb_src)
            rv_core_pkg::WB_ALU: wb_data = alu_result;
            rv_core_pkg::WB_PC4: wb_data = pc_plus4;
            rv_core_pkg::WB_MEM: wb_data = data_read_data;
            default:             wb_data = '0;
        endcase
    end

    assign wb_enable = !post_reset && rd != 5'd0 &&
                       (wb_src == rv_core_pkg::WB_ALU || wb_src == rv_core_pkg::WB_PC4 ||
                        (wb_src == rv_core_pkg::WB_MEM && load_pending));

    always_ff @(posedge clock) begin
        if (wb_enable) begin
            regs[rd] <= wb_data;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pc           <= '0;
            post_reset   <= 1'b1;
            load_pending <= 1'b0;
        end else begin
            pc           <= next_pc;
            post_reset   <= 1'b0;
            load_pending <= !post_reset && !load_pending && is_load && rd != 5'd0;
        end
    end

endmodule

// ==== hw/rv_data_ram.sv ====
module rv_data_ram #(
    parameter int DATA_BYTES = 1024
) (
    input  logic clock,
    input  logic [31:0] address,
    input  logic [2:0] func3,
    input  logic write,
    input  logic [31:0] write_data,
    output logic [31:0] read_data,
    input  logic [31:0] debug_address,
    output logic [31:0] debug_data
);

    localparam int ADDR_BITS = $clog2(DATA_BYTES);

    logic [7:0] mem [DATA_BYTES];
    logic [31:0] word;
    logic [2:0] store_bytes;

    // byte k of a word, wrapping at the top of memory
    function automatic logic [ADDR_BITS-1:0] byte_index(input logic [31:0] base, input int k);
        return base[ADDR_BITS-1:0] + ADDR_BITS'(k);
    endfunction

    initial begin
        for (int i = 0; i < DATA_BYTES; i++) begin
            mem[i] = 8'h00;
        end
    end

    always_comb begin
        case (rv_isa_pkg::mem_f3_e'(func3))
            rv_isa_pkg::MEM_B: store_bytes = 3'd1;
            rv_isa_pkg::MEM_H: store_bytes = 3'd2;
            rv_isa_pkg::MEM_W: store_bytes = 3'd4;
            default:           store_bytes = 3'd0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (write) begin
            for (int k = 0; k < 4; k++) begin
                if (k < int'(store_bytes)) begin
                    mem[byte_index(address, k)] <= write_data[8*k +: 8]; // little endian
                end
            end
        end
    end

    always_comb begin
        for (int k = 0; k < 4; k++) begin
            word[8*k +: 8]       = mem[byte_index(address, k)];
            debug_data[8*k +: 8] = mem[byte_index({debug_address[31:2], 2'b00}, k)];
        end
    end

    always_comb begin
        case (rv_isa_pkg::mem_f3_e'(func3))
            rv_isa_pkg::MEM_B:  read_data = {{24{word[7]}}, word[7:0]};
            rv_isa_pkg::MEM_H:  read_data = {{16{word[15]}}, word[15:0]};
            rv_isa_pkg::MEM_BU: read_data = {24'd0, word[7:0]};
            rv_isa_pkg::MEM_HU: read_data = {16'd0, word[15:0]};
            default:            read_data = word;
        endcase
    end

endmodule

// ==== hw/rv_program_ram.sv ====
module rv_program_ram #(
    parameter int PROGRAM_WORDS = 256
) (
    input  logic clock,
    input  logic [31:0] address,
    output logic [31:0] instruction,
    input  logic load_enable,
    input  logic [31:0] load_address,
    input  logic [31:0] load_data
);

    localparam int WORD_BITS = $clog2(PROGRAM_WORDS);

    logic [31:0] mem [PROGRAM_WORDS];

    always_ff @(posedge clock) begin
        if (load_enable) begin
            mem[load_address[WORD_BITS+1:2]] <= load_data;
        end
        instruction <= mem[address[WORD_BITS+1:2]]; // low two bits ignored
    end

endmodule

// ==== hw/rv_system.sv ====
module rv_system #(
    parameter int PROGRAM_WORDS = 256,
    parameter int DATA_BYTES    = 1024
) (
    input  logic clock,
    input  logic reset,
    input  logic load_enable,
    input  logic [31:0] load_address,
    input  logic [31:0] load_data,
    input  logic [31:0] debug_address,
    output logic [31:0] debug_data,
    output logic store_valid,
    output logic [31:0] store_address,
    output logic [31:0] store_data,
    output logic [2:0] store_func3
);

    logic [31:0] program_address, instruction, data_read_data;

    rv_core rv_core_i (
        .clock           (clock),
        .reset           (reset),
        .program_address (program_address),
        .instruction     (instruction),
        .data_address    (store_address),
        .data_func3      (store_func3),
        .data_write      (store_valid),
        .data_write_data (store_data),
        .data_read_data  (data_read_data)
    );

    rv_program_ram #(
        .PROGRAM_WORDS (PROGRAM_WORDS)
    ) rv_program_ram_i (
        .clock        (clock),
        .address      (program_address),
        .instruction  (instruction),
        .load_enable  (load_enable && reset), // loading only while held in reset
        .load_address (load_address),
        .load_data    (load_data)
    );

    rv_data_ram #(
        .DATA_BYTES (DATA_BYTES)
    ) rv_data_ram_i (
        .clock         (clock),
        .address       (store_address),
        .func3         (store_func3),
        .write         (store_valid),
        .write_data    (store_data),
        .read_data     (data_read_data),
        .debug_address (debug_address),
        .debug_data    (debug_data)
    );

endmodule

// ==== sim/rv_system_tb.sv ====
module rv_system_tb;

    localparam int PROGRAM_WORDS = 256;
    localparam int DATA_BYTES    = 1024;
    localparam int TIMEOUT       = 4000; // cycles per wait

    logic clock;
    logic reset;
    logic load_enable;
    logic [31:0] load_address;
    logic [31:0] load_data;
    logic [31:0] debug_address;
    logic [31:0] debug_data;
    logic store_valid;
    logic [31:0] store_address;
    logic [31:0] store_data;
    logic [2:0] store_func3;

    logic [31:0] program_words [$];
    logic [31:0] want_data [$];
    logic [31:0] want_address [$];
    rv_isa_pkg::mem_f3_e want_func3 [$];
    logic [31:0] seen_data [$];
    logic [31:0] seen_address [$];
    rv_isa_pkg::mem_f3_e seen_func3 [$];
    int mismatches;
    int timeouts;

    rv_system #(
        .PROGRAM_WORDS (PROGRAM_WORDS),
        .DATA_BYTES    (DATA_BYTES)
    ) rv_system_i (
        .clock         (clock),
        .reset         (reset),
        .load_enable   (load_enable),
        .load_address  (load_address),
        .load_data     (load_data),
        .debug_address (debug_address),
        .debug_data    (debug_data),
        .store_valid   (store_valid),
        .store_address (store_address),
        .store_data    (store_data),
        .store_func3   (store_func3)
    );

    always #10 clock = ~clock;

    // stores are sampled mid-cycle
    always @(negedge clock) begin
        if (store_valid) begin
            seen_data.push_back(store_data);
            seen_address.push_back(store_address);
            seen_func3.push_back(rv_isa_pkg::mem_f3_e'(store_func3));
        end
    end

    function automatic logic [31:0] r_type(rv_isa_pkg::alu_f3_e f3, rv_isa_pkg::funct7_e f7,
                                           logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OP_OP};
    endfunction

    function automatic logic [31:0] i_type(rv_isa_pkg::opcode_e op, logic [2:0] f3,
                                           logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(rv_isa_pkg::mem_f3_e f3, logic [4:0] rs1,
                                           logic [4:0] rs2, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_isa_pkg::OP_STORE};
    endfunction

    function automatic logic [31:0] b_type(rv_isa_pkg::branch_f3_e f3, logic [4:0] rs1,
                                           logic [4:0] rs2, logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_isa_pkg::OP_BRANCH};
    endfunction

    function automatic logic [31:0] u_type(rv_isa_pkg::opcode_e op, logic [4:0] rd,
                                           logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] j_type(logic [4:0] rd, logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_isa_pkg::OP_JAL};
    endfunction

    function automatic logic signed_less(logic [31:0] a, logic [31:0] b);
        if (a[31] != b[31]) begin
            return a[31]; // negative one is smaller
        end
        return a < b;
    endfunction

    function automatic logic [31:0] alu_model(rv_isa_pkg::alu_f3_e f3, logic alt,
                                              logic [31:0] a, logic [31:0] b);
        case (f3)
            rv_isa_pkg::F3_ADD:  return alt ? a - b : a + b;
            rv_isa_pkg::F3_SLL:  return a << b[4:0];
            rv_isa_pkg::F3_SLT:  return {31'd0, signed_less(a, b)};
            rv_isa_pkg::F3_SLTU: return {31'd0, a < b};
            rv_isa_pkg::F3_XOR:  return a ^ b;
            rv_isa_pkg::F3_SR: begin
                if (alt && a[31]) begin
                    return (a >> b[4:0]) | ~(32'hFFFF_FFFF >> b[4:0]); // fill with sign
                end
                return a >> b[4:0];
            end
            rv_isa_pkg::F3_OR:   return a | b;
            default:             return a & b;
        endcase
    endfunction

    function automatic logic branch_model(rv_isa_pkg::branch_f3_e f3, logic [31:0] a,
                                          logic [31:0] b);
        case (f3)
            rv_isa_pkg::BEQ:  return a == b;
            rv_isa_pkg::BNE:  return a != b;
            rv_isa_pkg::BLT:  return signed_less(a, b);
            rv_isa_pkg::BGE:  return !signed_less(a, b);
            rv_isa_pkg::BLTU: return a < b;
            default:          return !(a < b);
        endcase
    endfunction

    function automatic logic [31:0] load_model(rv_isa_pkg::mem_f3_e f3, logic [31:0] word,
                                               int offset);
        logic [31:0] shifted;
        shifted = word >> (8 * offset);
        case (f3)
            rv_isa_pkg::MEM_B:  return {{24{shifted[7]}}, shifted[7:0]};
            rv_isa_pkg::MEM_BU: return {24'd0, shifted[7:0]};
            rv_isa_pkg::MEM_H:  return {{16{shifted[15]}}, shifted[15:0]};
            rv_isa_pkg::MEM_HU: return {16'd0, shifted[15:0]};
            default:            return word;
        endcase
    endfunction

    function automatic void new_program();
        program_words.delete();
        want_data.delete();
        want_address.delete();
        want_func3.delete();
    endfunction

    function automatic void emit(logic [31:0] word);
        program_words.push_back(word);
    endfunction

    function automatic logic [31:0] here(); // address of the next word
        return 32'(4 * program_words.size());
    endfunction

    function automatic void set_reg(logic [4:0] rd, logic [31:0] value);
        logic [31:0] upper;
        upper = value + 32'h800; // addi sign-extends the low part
        emit(u_type(rv_isa_pkg::OP_LUI, rd, upper[31:12]));
        emit(i_type(rv_isa_pkg::OP_OP_IMM, rv_isa_pkg::F3_ADD, rd, rd, value[11:0]));
    endfunction

    function automatic void store(rv_isa_pkg::mem_f3_e f3, logic [4:0] rs1, logic [31:0] base,
                                  logic [4:0] rs2, logic [31:0] value, logic [11:0] offset);
        emit(s_type(f3, rs1, rs2, offset));
        want_address.push_back(base + {{20{offset[11]}}, offset});
        want_data.push_back(value);
        want_func3.push_back(f3);
    endfunction

    function automatic void store_result(logic [4:0] rs2, logic [31:0] value);
        store(rv_isa_pkg::MEM_W, 5'd0, 32'd0, rs2, value, 12'(32'h100 + 4 * want_data.size()));
    endfunction

    task automatic compare_word(logic [31:0] got, logic [31:0] want, string what);
        if (got !== want) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, want);
            mismatches++;
        end
    endtask

    task automatic compare_func3(rv_isa_pkg::mem_f3_e got, rv_isa_pkg::mem_f3_e want,
                                 string what);
        if (got !== want) begin
            $display("Mismatch at %0t: %s got %s expected %s", $time, what, got.name(),
                     want.name());
            mismatches++;
        end
    endtask

    // load the program while reset is held, then let the core run
    task automatic start_program();
        emit(j_type(5'd0, 21'd0)); // park
        foreach (program_words[i]) begin
            @(posedge clock);
            reset        <= 1'b1;
            load_enable  <= 1'b1;
            load_address <= 32'(4 * i);
            load_data    <= program_words[i];
        end
        @(posedge clock);
        load_enable <= 1'b0;
        seen_data.delete();
        seen_address.delete();
        seen_func3.delete();
        repeat (3) @(posedge clock);
        reset <= 1'b0;
    endtask

    task automatic wait_stores(int count, output bit ok);
        int cycles;
        cycles = 0;
        while (seen_data.size() < count && cycles < TIMEOUT) begin
            @(posedge clock);
            cycles++;
        end
        ok = seen_data.size() >= count;
        if (!ok) begin
            $display("timeout after %0d cycles: saw %0d stores, waited for %0d", cycles,
                     seen_data.size(), count);
            timeouts++;
        end
    endtask

    task automatic check_stores(string name, output bit ok);
        wait_stores(want_data.size(), ok);
        if (ok) begin
            foreach (want_data[i]) begin
                compare_word(seen_data[i], want_data[i], $sformatf("%s store %0d data", name, i));
                compare_word(seen_address[i], want_address[i],
                             $sformatf("%s store %0d address", name, i));
                compare_func3(seen_func3[i], want_func3[i],
                              $sformatf("%s store %0d size", name, i));
            end
        end
    endtask

    task automatic alu_test();
        logic [31:0] a, b, pc;
        logic [11:0] imm;
        logic [19:0] upper;
        rv_isa_pkg::alu_f3_e f3;
        rv_isa_pkg::funct7_e f7;
        bit ok;
        for (int round = 0; round < 2; round++) begin
            new_program();
            a = $urandom();
            b = $urandom();
            set_reg(5'd1, a);
            set_reg(5'd2, b);
            for (int f = 0; f < 8; f++) begin
                f3 = rv_isa_pkg::alu_f3_e'(f);
                for (int alt = 0; alt < 2; alt++) begin
                    if (alt == 1) begin
                        f7 = rv_isa_pkg::F7_ALT;
                    end else begin
                        f7 = rv_isa_pkg::F7_BASE;
                    end
                    if (alt == 0 || f3 == rv_isa_pkg::F3_ADD || f3 == rv_isa_pkg::F3_SR) begin
                        emit(r_type(f3, f7, 5'd3, 5'd1, 5'd2));
                        store_result(5'd3, alu_model(f3, alt == 1, a, b));
                    end
                    if (alt == 0 || f3 == rv_isa_pkg::F3_SR) begin // no subi
                        imm = 12'($urandom());
                        if (f3 == rv_isa_pkg::F3_SLL || f3 == rv_isa_pkg::F3_SR) begin
                            imm = {f7, imm[4:0]};
                        end
                        emit(i_type(rv_isa_pkg::OP_OP_IMM, f3, 5'd3, 5'd1, imm));
                        store_result(5'd3, alu_model(f3, alt == 1, a, {{20{imm[11]}}, imm}));
                    end
                end
            end
            upper = 20'($urandom());
            emit(u_type(rv_isa_pkg::OP_LUI, 5'd3, upper));
            store_result(5'd3, {upper, 12'h000});
            pc = here();
            emit(u_type(rv_isa_pkg::OP_AUIPC, 5'd3, upper));
            store_result(5'd3, pc + {upper, 12'h000});
            start_program();
            check_stores("alu", ok);
        end
    endtask

    task automatic branch_test();
        logic [31:0] values [4];
        logic [4:0] first [3];
        logic [4:0] second [3];
        rv_isa_pkg::branch_f3_e kinds [6];
        int marker;
        logic taken;
        bit ok;
        values = '{32'd0, 32'hFFFF_FFF0, 32'h0000_0010, 32'hFFFF_FFF0}; // signed and unsigned disagree
        first  = '{5'd1, 5'd2, 5'd1};
        second = '{5'd2, 5'd1, 5'd3};
        kinds  = '{rv_isa_pkg::BEQ, rv_isa_pkg::BNE, rv_isa_pkg::BLT, rv_isa_pkg::BGE,
                   rv_isa_pkg::BLTU, rv_isa_pkg::BGEU};
        new_program();
        for (int r = 1; r < 4; r++) begin
            set_reg(5'(r), values[r]);
        end
        for (int p = 0; p < 3; p++) begin
            for (int k = 0; k < 6; k++) begin
                marker = 2 * (6 * p + k) + 16;
                taken  = branch_model(kinds[k], values[first[p]], values[second[p]]);
                emit(b_type(kinds[k], first[p], second[p], 13'd12));
                emit(i_type(rv_isa_pkg::OP_OP_IMM, rv_isa_pkg::F3_ADD, 5'd5, 5'd0, 12'(marker)));
                emit(j_type(5'd0, 21'd8));
                emit(i_type(rv_isa_pkg::OP_OP_IMM, rv_isa_pkg::F3_ADD, 5'd5, 5'd0,
                            12'(marker + 1)));
                store_result(5'd5, taken ? 32'(marker + 1) : 32'(marker));
            end
        end
        start_program();
        check_stores("branch", ok);
    endtask

    task automatic jump_test();
        logic [31:0] link, landing;
        bit ok;
        new_program();
        link = here() + 32'd4;
        emit(j_type(5'd1, 21'd8));
        emit(s_type(rv_isa_pkg::MEM_W, 5'd0, 5'd0, 12'h1F0)); // skipped by jal
        store_result(5'd1, link);
        emit(u_type(rv_isa_pkg::OP_AUIPC, 5'd2, 20'd0));
        emit(i_type(rv_isa_pkg::OP_OP_IMM, rv_isa_pkg::F3_ADD, 5'd2, 5'd2, 12'd21)); // odd target
        link = here() + 32'd4;
        emit(i_type(rv_isa_pkg::OP_JALR, 3'd0, 5'd3, 5'd2, 12'd0));
        emit(i_type(rv_isa_pkg::OP_OP_IMM, rv_isa_pkg::F3_ADD, 5'd4, 5'd0, 12'h0AA));
        emit(s_type(rv_isa_pkg::MEM_W, 5'd0, 5'd4, 12'h1F4));
        landing = here();
        emit(u_type(rv_isa_pkg::OP_AUIPC, 5'd6, 20'd0)); // jalr lands with bit 0 clear
        emit(i_type(rv_isa_pkg::OP_OP_IMM, rv_isa_pkg::F3_ADD, 5'd4, 5'd0, 12'h055));
        store_result(5'd4, 32'h55);
        store_result(5'd6, landing);
        store_result(5'd3, link);
        emit(i_type(rv_isa_pkg::OP_OP_IMM, rv_isa_pkg::F3_ADD, 5'd0, 5'd0, 12'h123));
        emit(j_type(5'd0, 21'd4));
        store_result(5'd0, 32'd0);
        start_program();
        check_stores("jump", ok);
    endtask

    task automatic load_store_test();
        logic [31:0] base, word;
        rv_isa_pkg::mem_f3_e kinds [5];
        int offsets [5];
        bit ok;
        base    = 32'h200;
        word    = $urandom() | 32'h8080_8080; // every byte negative
        kinds   = '{rv_isa_pkg::MEM_B, rv_isa_pkg::MEM_BU, rv_isa_pkg::MEM_H, rv_isa_pkg::MEM_HU,
                    rv_isa_pkg::MEM_W};
        offsets = '{0, 1, 2, 0, 0};
        new_program();
        set_reg(5'd1, base);
        set_reg(5'd2, word);
        set_reg(5'd3, word >> 8);
        set_reg(5'd4, word >> 16);
        store(rv_isa_pkg::MEM_B, 5'd1, base, 5'd2, word, 12'd0);
        store(rv_isa_pkg::MEM_B, 5'd1, base, 5'd3, word >> 8, 12'd1);
        store(rv_isa_pkg::MEM_H, 5'd1, base, 5'd4, word >> 16, 12'd2);
        for (int k = 0; k < 5; k++) begin
            emit(i_type(rv_isa_pkg::OP_LOAD, kinds[k], 5'd5, 5'd1, 12'(offsets[k])));
            store(rv_isa_pkg::MEM_W, 5'd1, base, 5'd5, load_model(kinds[k], word, offsets[k]),
                  12'(16 + 4 * k));
        end
        emit(i_type(rv_isa_pkg::OP_LOAD, rv_isa_pkg::MEM_W, 5'd6, 5'd1, 12'd0));
        emit(i_type(rv_isa_pkg::OP_OP_IMM, rv_isa_pkg::F3_ADD, 5'd7, 5'd6, 12'd1)); // uses x6 at once
        store(rv_isa_pkg::MEM_W, 5'd1, base, 5'd7, word + 32'd1, 12'h030);
        start_program();
        check_stores("load/store", ok);
        @(posedge clock);
        debug_address <= base;
        @(negedge clock);
        compare_word(debug_data, word, "debug read of the byte-assembled word");
    endtask

    task automatic reset_test();
        logic [31:0] base, value, first_data, first_address;
        rv_isa_pkg::mem_f3_e first_func3;
        bit ok;
        base  = 32'h300;
        value = $urandom();
        new_program();
        set_reg(5'd1, base);
        set_reg(5'd2, value);
        store(rv_isa_pkg::MEM_W, 5'd1, base, 5'd2, value, 12'h004);
        store(rv_isa_pkg::MEM_H, 5'd1, base, 5'd2, value, 12'h00A);
        store(rv_isa_pkg::MEM_B, 5'd1, base, 5'd2, value, 12'h00D);
        store(rv_isa_pkg::MEM_W, 5'd1, base, 5'd2, value, 12'hFFC); // negative offset
        emit(i_type(rv_isa_pkg::OP_OP_IMM, rv_isa_pkg::F3_ADD, 5'd3, 5'd3, 12'd1));
        emit(s_type(rv_isa_pkg::MEM_W, 5'd1, 5'd3, 12'h040));
        emit(j_type(5'd0, 21'h1FFFF8)); // back two words to store forever
        start_program();
        check_stores("store ports", ok);
        if (ok) begin
            first_data    = seen_data[0];
            first_address = seen_address[0];
            first_func3   = seen_func3[0];
            @(posedge clock);
            reset <= 1'b1;
            seen_data.delete();
            seen_address.delete();
            seen_func3.delete();
            repeat (4) @(posedge clock);
            compare_word(32'(seen_data.size()), 32'd0, "stores while reset held");
            reset <= 1'b0;
            wait_stores(1, ok);
            if (ok) begin
                compare_word(seen_data[0], first_data, "first store data after reset");
                compare_word(seen_address[0], first_address, "first store address after reset");
                compare_func3(seen_func3[0], first_func3, "first store size after reset");
            end
        end
    endtask

    initial begin
        void'($urandom(32'h97cfb3f8));
        clock         = 1'b0;
        reset         = 1'b1;
        load_enable   = 1'b0;
        load_address  = '0;
        load_data     = '0;
        debug_address = '0;
        mismatches    = 0;
        timeouts      = 0;
        alu_test();
        branch_test();
        jump_test();
        load_store_test();
        reset_test();
        $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== rv_system.f ====
hw/rv_isa_pkg.sv
hw/rv_core_pkg.sv
hw/rv_alu.sv
hw/rv_decoder.sv
hw/rv_core.sv
hw/rv_data_ram.sv
hw/rv_program_ram.sv
hw/rv_system.sv
sim/rv_system_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rv_system_tb
FILELIST  ?= rv_system.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_TEXT ?= Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
